// ==== source/gpio_pkg.sv ====
package gpio_pkg;

   // ####################
   // Widths
   // ####################

   localparam int AW = 32;                       // Mesh address and data width
   localparam int PW = 2*AW + 40;                // Packet width (104)

   typedef logic [AW-1:0] addr_t;                // Mesh address
   typedef logic [AW-1:0] data_t;                // Data word
   typedef logic [PW-1:0] packet_t;              // Full mesh packet

   // ####################
   // Packet fields
   // ####################

   localparam int WRITE_BIT = 0;                 // 1 = write, 0 = read
   localparam int DMODE_LSB = 1;                 // Datamode
   localparam int DMODE_MSB = 2;
   localparam int CMODE_LSB = 3;                 // Ctrlmode
   localparam int CMODE_MSB = 7;
   localparam int DST_LSB   = 8;                 // Destination address
   localparam int DST_MSB   = 39;
   localparam int DATA_LSB  = 40;                // Write data or read payload
   localparam int DATA_MSB  = 71;
   localparam int SRC_LSB   = 72;                // Return address for reads
   localparam int SRC_MSB   = 103;

   // ####################
   // Register map
   // ####################

   // Compared against dstaddr[6:3]
   localparam logic [3:0] REG_DIR     = 4'd0;    // Pin direction (1 = output)
   localparam logic [3:0] REG_IN      = 4'd1;    // Synchronized pin inputs
   localparam logic [3:0] REG_OUT     = 4'd2;    // Output data
   localparam logic [3:0] REG_OUTCLR  = 4'd3;    // Clear bits in output
   localparam logic [3:0] REG_OUTSET  = 4'd4;    // Set bits in output
   localparam logic [3:0] REG_OUTXOR  = 4'd5;    // Toggle bits in output
   localparam logic [3:0] REG_IMASK   = 4'd6;    // Interrupt mask (1 = masked)
   localparam logic [3:0] REG_ITYPE   = 4'd7;    // 0 = edge, 1 = level
   localparam logic [3:0] REG_IPOL    = 4'd8;    // 0 = falling/low, 1 = rising/high
   localparam logic [3:0] REG_ILAT    = 4'd9;    // Interrupt latch
   localparam logic [3:0] REG_ILATCLR = 4'd10;   // Write ones to clear latch bits

endpackage

// ==== source/gpio_regs.sv ====
`timescale 1ns/100ps

module gpio_regs #(
   parameter int N = 24                          // Pin count up to 32
) (
   input  logic                clk,
   input  logic                nreset,
   input  logic                take,             // Request accepted at this edge
   input  gpio_pkg::packet_t   packet_in,
   input  logic [N-1:0]        gpio_in_sync,     // Pins after synchronizer
   input  logic [N-1:0]        gpio_ilat,        // Interrupt latch for readback
   output logic [N-1:0]        gpio_dir,
   output logic [N-1:0]        gpio_out,
   output logic [N-1:0]        gpio_imask,
   output logic [N-1:0]        gpio_itype,
   output logic [N-1:0]        gpio_ipol,
   output logic [N-1:0]        ilat_clr,         // One-cycle clear mask
   output gpio_pkg::data_t     read_data         // Payload for the response
);

   logic              write_in;
   gpio_pkg::addr_t   dstaddr_in;
   gpio_pkg::data_t   data_in;
   logic [3:0]        reg_sel;
   logic [N-1:0]      reg_wdata;
   logic              reg_write;
   logic              reg_read;
   logic              dir_write;
   logic              out_write;
   logic              outclr_write;
   logic              outset_write;
   logic              outxor_write;
   logic              imask_write;
   logic              itype_write;
   logic              ipol_write;
   logic              ilatclr_write;
   logic              out_reg_write;
   logic [N-1:0]      out_next;
   gpio_pkg::data_t   rd_mux;

   // ####################
   // Decode
   // ####################

   assign write_in   = packet_in[gpio_pkg::WRITE_BIT];
   assign dstaddr_in = packet_in[gpio_pkg::DST_MSB:gpio_pkg::DST_LSB];
   assign data_in    = packet_in[gpio_pkg::DATA_MSB:gpio_pkg::DATA_LSB];

   assign reg_sel    = dstaddr_in[6:3];          // Word offset within block
   assign reg_wdata  = data_in[N-1:0];           // Upper data bits ignored
   assign reg_write  = take & write_in;
   assign reg_read   = take & ~write_in;

   // One strobe per register offset
   assign dir_write     = reg_write & (reg_sel == gpio_pkg::REG_DIR);
   assign out_write     = reg_write & (reg_sel == gpio_pkg::REG_OUT);
   assign outclr_write  = reg_write & (reg_sel == gpio_pkg::REG_OUTCLR);
   assign outset_write  = reg_write & (reg_sel == gpio_pkg::REG_OUTSET);
   assign outxor_write  = reg_write & (reg_sel == gpio_pkg::REG_OUTXOR);
   assign imask_write   = reg_write & (reg_sel == gpio_pkg::REG_IMASK);
   assign itype_write   = reg_write & (reg_sel == gpio_pkg::REG_ITYPE);
   assign ipol_write    = reg_write & (reg_sel == gpio_pkg::REG_IPOL);
   assign ilatclr_write = reg_write & (reg_sel == gpio_pkg::REG_ILATCLR);

   assign out_reg_write = out_write | outclr_write | outset_write | outxor_write;

   // Latch clear goes straight to the irq block
   assign ilat_clr = ilatclr_write ? reg_wdata : '0;

   // ####################
   // Output register
   // ####################

   always_comb begin
      out_next = reg_wdata;                      // Plain write
      if (outclr_write) begin
         out_next = gpio_out & ~reg_wdata;       // Clear where data is 1
      end else if (outset_write) begin
         out_next = gpio_out | reg_wdata;        // Set where data is 1
      end else if (outxor_write) begin
         out_next = gpio_out ^ reg_wdata;        // Toggle where data is 1
      end
   end

   // ####################
   // Control registers
   // ####################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         gpio_dir   <= '0;                       // All pins input
         gpio_out   <= '0;
         gpio_imask <= '1;                       // Interrupts off until unmasked
         gpio_itype <= '0;                       // Edge mode
         gpio_ipol  <= '0;
      end else begin
         if (dir_write) begin
            gpio_dir <= reg_wdata;
         end
         if (out_reg_write) begin
            gpio_out <= out_next;
         end
         if (imask_write) begin
            gpio_imask <= reg_wdata;
         end
         if (itype_write) begin
            gpio_itype <= reg_wdata;
         end
         if (ipol_write) begin
            gpio_ipol <= reg_wdata;
         end
      end
   end

   // ####################
   // Readback
   // ####################

   always_comb begin
      rd_mux = '0;                               // Bits above N read zero
      case (reg_sel)
         gpio_pkg::REG_IN:   rd_mux[N-1:0] = gpio_in_sync;
         gpio_pkg::REG_ILAT: rd_mux[N-1:0] = gpio_ilat;
         gpio_pkg::REG_DIR:  rd_mux[N-1:0] = gpio_dir;
         gpio_pkg::REG_OUT:  rd_mux[N-1:0] = gpio_out;
         default:            rd_mux[N-1:0] = '0;  // Write-only or unused
      endcase
   end

   // Captured at the take edge and held until the next taken read
   always_ff @(posedge clk) begin
      if (reg_read) begin
         read_data <= rd_mux;
      end
   end

endmodule

// ==== source/gpio_irq.sv ====
`timescale 1ns/100ps

module gpio_irq #(
   parameter int N = 24                          // Pin count, at most 32
) (
   input  logic           clk,
   input  logic           nreset,
   input  logic [N-1:0]   gpio_in,               // Raw pins, asynchronous
   input  logic [N-1:0]   gpio_imask,            // 1 blocks the latch
   input  logic [N-1:0]   gpio_itype,            // 0 = edge, 1 = level
   input  logic [N-1:0]   gpio_ipol,             // 1 = rising or high
   input  logic [N-1:0]   ilat_clr,              // From ILATCLR write
   output logic [N-1:0]   gpio_in_sync,
   output logic [N-1:0]   gpio_ilat,
   output logic           gpio_irq
);

   logic [N-1:0] sync_q1;                        // First synchronizer stage
   logic [N-1:0] gpio_in_old;                    // Synced value one cycle back
   logic [N-1:0] rising_edge;
   logic [N-1:0] falling_edge;
   logic [N-1:0] irq_event;

   // ####################
   // Input synchronizer
   // ####################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         sync_q1      <= '0;
         gpio_in_sync <= '0;
         gpio_in_old  <= '0;
      end else begin
         sync_q1      <= gpio_in;                // Two flops to settle metastability
         gpio_in_sync <= sync_q1;
         gpio_in_old  <= gpio_in_sync;           // For edge detect
      end
   end

   assign rising_edge  =  gpio_in_sync & ~gpio_in_old;
   assign falling_edge = ~gpio_in_sync &  gpio_in_old;

   // ####################
   // Event select
   // ####################

   // Per bit, type picks edge or level and polarity picks the sense
   assign irq_event = (rising_edge   & ~gpio_itype &  gpio_ipol) |
                      (falling_edge  & ~gpio_itype & ~gpio_ipol) |
                      (gpio_in_sync  &  gpio_itype &  gpio_ipol) |
                      (~gpio_in_sync &  gpio_itype & ~gpio_ipol);

   // ####################
   // Interrupt latch
   // ####################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         gpio_ilat <= '0;
      end else begin
         // New event wins over a clear of the same bit
         gpio_ilat <= (gpio_ilat & ~ilat_clr) |
                      (irq_event & ~gpio_imask);
      end
   end

   assign gpio_irq = |gpio_ilat;                 // Any latched bit raises irq

   // Mask sampled at the same edge as the event
   a_masked_no_latch: assert property (@(posedge clk) disable iff (!nreset)
      ((gpio_ilat & ~$past(gpio_ilat) & $past(gpio_imask)) == '0));

endmodule

// ==== source/emesh_readback.sv ====
`timescale 1ns/100ps

module emesh_readback (
   input  logic                clk,
   input  logic                nreset,
   input  logic                access_in,        // Request valid from mesh
   input  gpio_pkg::packet_t   packet_in,
   input  logic                wait_in,          // Pushback on our response
   input  gpio_pkg::data_t     read_data,        // Registered readback word
   output logic                take,             // Request accepted this edge
   output logic                wait_out,         // Pushback to requester
   output logic                access_out,       // Response valid
   output gpio_pkg::packet_t   packet_out
);

   logic                                                write_in;
   logic                                                read_take;
   logic [gpio_pkg::DMODE_MSB-gpio_pkg::DMODE_LSB:0]    datamode_q;
   logic [gpio_pkg::CMODE_MSB-gpio_pkg::CMODE_LSB:0]    ctrlmode_q;
   gpio_pkg::addr_t                                     dstaddr_q;

   // ####################
   // Acceptance
   // ####################

   assign write_in  = packet_in[gpio_pkg::WRITE_BIT];
   assign take      = access_in & ~wait_out;     // Sender holds while stalled
   assign read_take = take & ~write_in;          // Only reads make a response

   // Stall requests while an undelivered response is pushed back
   assign wait_out  = access_out & wait_in;

   // ####################
   // Response valid
   // ####################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         access_out <= 1'b0;
      end else if (read_take) begin
         access_out <= 1'b1;                     // Valid one cycle after take
      end else if (!wait_in) begin
         access_out <= 1'b0;                     // Delivered at this edge
      end
   end

   // Header fields, loaded with the request
   always_ff @(posedge clk) begin
      if (read_take) begin
         datamode_q <= packet_in[gpio_pkg::DMODE_MSB:gpio_pkg::DMODE_LSB];
         ctrlmode_q <= packet_in[gpio_pkg::CMODE_MSB:gpio_pkg::CMODE_LSB];
         dstaddr_q  <= packet_in[gpio_pkg::SRC_MSB:gpio_pkg::SRC_LSB];  // Return path
      end
   end

   // ####################
   // Response packet
   // ####################

   always_comb begin
      packet_out = '0;                           // Srcaddr stays zero
      packet_out[gpio_pkg::WRITE_BIT] = 1'b1;    // Response is a write back
      packet_out[gpio_pkg::DMODE_MSB:gpio_pkg::DMODE_LSB] = datamode_q;
      packet_out[gpio_pkg::CMODE_MSB:gpio_pkg::CMODE_LSB] = ctrlmode_q;
      packet_out[gpio_pkg::DST_MSB:gpio_pkg::DST_LSB]     = dstaddr_q;
      packet_out[gpio_pkg::DATA_MSB:gpio_pkg::DATA_LSB]   = read_data;
   end

   // Payload comes from the register block, so a stall must freeze both sides
   a_hold_stall: assert property (@(posedge clk) disable iff (!nreset)
      (access_out && wait_in) |=> (access_out && $stable(packet_out)));

endmodule

// ==== source/gpio.sv ====
`timescale 1ns/100ps

module gpio #(
   parameter int N = 24                          // Pin count, at most 32
) (
   input  logic                clk,
   input  logic                nreset,           // Async, active low
   input  logic                access_in,        // Mesh request valid
   input  gpio_pkg::packet_t   packet_in,
   input  logic                wait_in,          // Pushback on response
   input  logic [N-1:0]        gpio_in,          // From IO pins
   output logic                wait_out,         // Pushback to mesh
   output logic                access_out,       // Response valid
   output gpio_pkg::packet_t   packet_out,
   output logic [N-1:0]        gpio_out,         // To IO pins
   output logic [N-1:0]        gpio_dir,         // 1 = drive pin
   output logic                gpio_irq          // OR of latch
);

   logic              take;
   gpio_pkg::data_t   read_data;
   logic [N-1:0]      gpio_in_sync;
   logic [N-1:0]      gpio_ilat;
   logic [N-1:0]      gpio_imask;
   logic [N-1:0]      gpio_itype;
   logic [N-1:0]      gpio_ipol;
   logic [N-1:0]      ilat_clr;

   // Register file and readback mux
   gpio_regs #(.N(N)) u_regs (
      .clk          (clk),
      .nreset       (nreset),
      .take         (take),
      .packet_in    (packet_in),
      .gpio_in_sync (gpio_in_sync),
      .gpio_ilat    (gpio_ilat),
      .gpio_dir     (gpio_dir),
      .gpio_out     (gpio_out),
      .gpio_imask   (gpio_imask),
      .gpio_itype   (gpio_itype),
      .gpio_ipol    (gpio_ipol),
      .ilat_clr     (ilat_clr),
      .read_data    (read_data)
   );

   // Pin sync and interrupt latch
   gpio_irq #(.N(N)) u_irq (
      .clk          (clk),
      .nreset       (nreset),
      .gpio_in      (gpio_in),
      .gpio_imask   (gpio_imask),
      .gpio_itype   (gpio_itype),
      .gpio_ipol    (gpio_ipol),
      .ilat_clr     (ilat_clr),
      .gpio_in_sync (gpio_in_sync),
      .gpio_ilat    (gpio_ilat),
      .gpio_irq     (gpio_irq)
   );

   // Mesh handshake and read response
   emesh_readback u_readback (
      .clk          (clk),
      .nreset       (nreset),
      .access_in    (access_in),
      .packet_in    (packet_in),
      .wait_in      (wait_in),
      .read_data    (read_data),
      .take         (take),
      .wait_out     (wait_out),
      .access_out   (access_out),
      .packet_out   (packet_out)
   );

endmodule

// ==== tests/gpio_clkgen.sv ====
`timescale 1ns/100ps

module gpio_clkgen (
   output logic clk,
   output logic nreset
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      nreset = 1'b0;                             // Held over 4 rising edges
      repeat (4) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
   end

endmodule

// ==== tests/gpio_tb.sv ====
`timescale 1ns/100ps

module gpio_tb;

   localparam int N = 24;
   localparam logic [31:0] NMASK = 32'hffff_ffff >> (32 - N);   // Pins in use

   logic               clk;
   logic               nreset;
   logic               access_in;
   logic               wait_in;
   logic               wait_out;
   logic               access_out;
   logic               gpio_irq;
   gpio_pkg::packet_t  packet_in;
   gpio_pkg::packet_t  packet_out;
   logic [N-1:0]       gpio_in;
   logic [N-1:0]       gpio_out;
   logic [N-1:0]       gpio_dir;

   // Register model
   logic [31:0] model_dir = '0;
   logic [31:0] model_out = '0;
   logic [31:0] model_imask = NMASK;
   logic [31:0] model_itype = '0;
   logic [31:0] model_ipol = '0;
   logic [31:0] model_ilat = '0;
   logic [31:0] pins = '0;                       // Value held on gpio_in
   logic [31:0] rd;                              // Last read payload
   logic [31:0] lfsr = 32'h39e32ede;
   int errors = 0;
   int checks = 0;
   int cycles = 0;

   gpio_clkgen clkgen (.clk(clk), .nreset(nreset));

   gpio #(.N(N)) uut (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .gpio_in    (gpio_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .gpio_out   (gpio_out),
      .gpio_dir   (gpio_dir),
      .gpio_irq   (gpio_irq)
   );

   // ####################
   // Helpers
   // ####################

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] random_bits(input int nbits);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Mode is ctrlmode above datamode in bits 7..1
   function automatic gpio_pkg::packet_t make_packet(input logic wr, input logic [3:0] sel,
         input logic [31:0] data, input logic [31:0] src, input logic [6:0] mode);
      gpio_pkg::packet_t p;
      p = '0;
      p[gpio_pkg::WRITE_BIT] = wr;
      p[gpio_pkg::CMODE_MSB:gpio_pkg::DMODE_LSB] = mode;
      p[gpio_pkg::DST_MSB:gpio_pkg::DST_LSB] = {25'd0, sel, 3'd0};   // Word offset
      p[gpio_pkg::DATA_MSB:gpio_pkg::DATA_LSB] = data;
      p[gpio_pkg::SRC_MSB:gpio_pkg::SRC_LSB] = src;
      return p;
   endfunction

   // Unmasked level-type bits whose level matches the polarity
   function automatic logic [31:0] level_events(input logic [31:0] p);
      return ((p & model_ipol) | (~p & ~model_ipol)) & model_itype & ~model_imask & NMASK;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
         input logic [31:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic test_done(input string name, input int e0);
      $display("%s: %0d errors", name, errors - e0);
   endtask

   // One request taken at the rising edge between two falling edges
   task automatic issue(input gpio_pkg::packet_t p);
      @(negedge clk);
      check_value("wait_out", 32'd0, 32'(wait_out));
      access_in = 1'b1;
      packet_in = p;
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic write_reg(input logic [3:0] sel, input logic [31:0] data);
      logic [31:0] d;
      d = data & NMASK;                          // Upper bits ignored
      issue(make_packet(1'b1, sel, data, 32'd0, 7'd0));
      case (sel)
         gpio_pkg::REG_DIR:     model_dir = d;
         gpio_pkg::REG_OUT:     model_out = d;
         gpio_pkg::REG_OUTCLR:  model_out &= ~d;
         gpio_pkg::REG_OUTSET:  model_out |= d;
         gpio_pkg::REG_OUTXOR:  model_out ^= d;
         gpio_pkg::REG_IMASK:   model_imask = d;
         gpio_pkg::REG_ITYPE:   model_itype = d;
         gpio_pkg::REG_IPOL:    model_ipol = d;
         gpio_pkg::REG_ILATCLR: model_ilat &= ~d;
         default: ;
      endcase
   endtask

   task automatic read_check(input logic [3:0] sel, input logic [31:0] exp,
         output logic [31:0] got);
      logic [31:0] src;
      logic [6:0] mode;
      int waited;
      src = random_bits(32);
      mode = 7'(random_bits(7));
      waited = 0;
      issue(make_packet(1'b0, sel, 32'd0, src, mode));
      while (!access_out && waited < 8) begin
         @(negedge clk);
         waited++;
      end
      assert (access_out) else begin
         errors++;
         $display("%0t: no read response within 8 cycles", $time);
      end
      got = packet_out[gpio_pkg::DATA_MSB:gpio_pkg::DATA_LSB];
      check_value("packet_out data", exp, got);
      check_value("packet_out write", 32'd1, 32'(packet_out[gpio_pkg::WRITE_BIT]));
      check_value("packet_out mode", 32'(mode),
                  32'(packet_out[gpio_pkg::CMODE_MSB:gpio_pkg::DMODE_LSB]));
      check_value("packet_out dstaddr", src, packet_out[gpio_pkg::DST_MSB:gpio_pkg::DST_LSB]);
      check_value("packet_out srcaddr", 32'd0, packet_out[gpio_pkg::SRC_MSB:gpio_pkg::SRC_LSB]);
   endtask

   // ####################
   // Tests
   // ####################

   task automatic test_reset();
      int e0;
      e0 = errors;
      @(negedge clk);
      check_value("gpio_dir", 32'd0, 32'(gpio_dir));
      check_value("gpio_out", 32'd0, 32'(gpio_out));
      check_value("gpio_irq", 32'd0, 32'(gpio_irq));
      check_value("access_out", 32'd0, 32'(access_out));
      check_value("wait_out", 32'd0, 32'(wait_out));
      read_check(gpio_pkg::REG_DIR, 32'd0, rd);
      read_check(gpio_pkg::REG_OUT, 32'd0, rd);
      read_check(gpio_pkg::REG_ILAT, 32'd0, rd);
      read_check(4'd13, 32'd0, rd);              // Unused offset
      test_done("reset state", e0);
   endtask

   task automatic test_output();
      int e0;
      int k;
      logic [3:0] sel;
      e0 = errors;
      for (int i = 0; i < 15; i++) begin
         k = random_bits(8) % 5;
         sel = (k == 0) ? gpio_pkg::REG_DIR : 4'(k + 1);   // Offsets 2..5 are output ops
         write_reg(sel, random_bits(32));
         check_value("gpio_dir", model_dir, 32'(gpio_dir));
         check_value("gpio_out", model_out, 32'(gpio_out));
         read_check(gpio_pkg::REG_DIR, model_dir, rd);
         read_check(gpio_pkg::REG_OUT, model_out, rd);
      end
      test_done("output control", e0);
   endtask

   task automatic test_input();
      int e0;
      e0 = errors;
      for (int i = 0; i < 3; i++) begin
         @(negedge clk);
         pins = random_bits(N);
         gpio_in = pins[N-1:0];
         repeat (5) @(negedge clk);              // Past the synchronizer
         read_check(gpio_pkg::REG_IN, pins, rd);
      end
      test_done("input readback", e0);
   endtask

   task automatic test_edge_irq();
      int e0;
      logic [31:0] old;
      e0 = errors;
      write_reg(gpio_pkg::REG_ITYPE, 32'd0);
      write_reg(gpio_pkg::REG_IPOL, random_bits(N));
      write_reg(gpio_pkg::REG_IMASK, random_bits(N));
      for (int i = 0; i < 4; i++) begin
         old = pins;
         @(negedge clk);
         pins = old ^ random_bits(N);            // Toggle a random set
         gpio_in = pins[N-1:0];
         repeat (5) @(negedge clk);
         model_ilat |= ((pins & ~old & model_ipol) | (~pins & old & ~model_ipol))
                       & ~model_itype & ~model_imask & NMASK;
         read_check(gpio_pkg::REG_ILAT, model_ilat, rd);
         check_value("ilat masked bits", 32'd0, rd & model_imask);
         check_value("gpio_irq", 32'(|model_ilat), 32'(gpio_irq));
      end
      write_reg(gpio_pkg::REG_ILATCLR, random_bits(N));
      read_check(gpio_pkg::REG_ILAT, model_ilat, rd);
      check_value("gpio_irq", 32'(|model_ilat), 32'(gpio_irq));
      test_done("edge interrupts", e0);
   endtask

   task automatic test_level_irq();
      int e0;
      e0 = errors;
      write_reg(gpio_pkg::REG_IMASK, NMASK);     // Quiet while the mode changes
      write_reg(gpio_pkg::REG_ITYPE, NMASK);
      write_reg(gpio_pkg::REG_IPOL, random_bits(N));
      write_reg(gpio_pkg::REG_ILATCLR, NMASK);
      write_reg(gpio_pkg::REG_IMASK, random_bits(N));
      for (int i = 0; i < 3; i++) begin
         if (i > 0) begin
            @(negedge clk);
            pins = pins ^ random_bits(N);
            gpio_in = pins[N-1:0];
         end
         repeat (5) @(negedge clk);
         model_ilat |= level_events(pins);       // Old bits stay latched
         read_check(gpio_pkg::REG_ILAT, model_ilat, rd);
         check_value("gpio_irq", 32'(|model_ilat), 32'(gpio_irq));
      end
      write_reg(gpio_pkg::REG_ILATCLR, NMASK);
      model_ilat = level_events(pins);           // Held levels latch again
      read_check(gpio_pkg::REG_ILAT, model_ilat, rd);
      check_value("gpio_irq", 32'(|model_ilat), 32'(gpio_irq));
      test_done("level interrupts", e0);
   endtask

   task automatic test_backpressure();
      int e0;
      int delivered;
      logic [31:0] src;
      logic [31:0] data;
      gpio_pkg::packet_t held;
      e0 = errors;
      delivered = 0;
      src = random_bits(32);
      data = random_bits(32);
      @(negedge clk);
      wait_in = 1'b1;
      access_in = 1'b1;
      packet_in = make_packet(1'b0, gpio_pkg::REG_DIR, 32'd0, src, 7'h5a);
      @(negedge clk);
      packet_in = make_packet(1'b1, gpio_pkg::REG_OUT, data, 32'd0, 7'd0);   // Held in stall
      held = packet_out;
      check_value("packet_out data", model_dir, held[gpio_pkg::DATA_MSB:gpio_pkg::DATA_LSB]);
      check_value("packet_out dstaddr", src, held[gpio_pkg::DST_MSB:gpio_pkg::DST_LSB]);
      repeat (4) begin
         @(negedge clk);
         check_value("access_out", 32'd1, 32'(access_out));
         check_value("wait_out", 32'd1, 32'(wait_out));
         check_value("gpio_out", model_out, 32'(gpio_out));
         checks++;
         assert (packet_out === held) else begin
            errors++;
            $display("ERR %0t packet_out expected %h got %h", $time, held, packet_out);
         end
      end
      wait_in = 1'b0;                            // Release lets the response go at the next edge
      for (int i = 0; i < 4; i++) begin
         if (access_out) begin
            delivered++;
         end
         @(negedge clk);
         if (i == 0) begin
            access_in = 1'b0;
            model_out = data & NMASK;            // Write taken with the delivery
            check_value("gpio_out", model_out, 32'(gpio_out));
         end
      end
      checks++;
      assert (delivered == 1) else begin
         errors++;
         $display("%0t: stalled response delivered %0d times", $time, delivered);
      end
      read_check(gpio_pkg::REG_OUT, model_out, rd);
      test_done("back-pressure", e0);
   endtask

   // ####################
   // Main sequence
   // ####################

   initial begin
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      gpio_in   = '0;
      @(posedge nreset);
      test_reset();
      test_output();
      test_input();
      test_edge_irq();
      test_level_irq();
      test_backpressure();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Run limit well above the length of all tests
   always @(posedge clk) begin
      cycles++;
      if (cycles >= 2000) begin
         $display("Timeout after %0d cycles", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

endmodule

// ==== gpio.f ====
source/gpio_pkg.sv
source/gpio_regs.sv
source/gpio_irq.sv
source/emesh_readback.sv
source/gpio.sv
tests/gpio_clkgen.sv
tests/gpio_tb.sv

// ==== Makefile ====
TOP = gpio_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f gpio.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

lint:
	verilator --lint-only --timing --top-module gpio -f gpio.f

clean:
	rm -rf obj_dir sim.log
